// File: hdl/mcu_obi_pkg.sv
////////////////////////////////////////////////////////////////////////////
// OBI bus types shared by the master port, the system bus and the slaves
////////////////////////////////////////////////////////////////////////////

package mcu_obi_pkg;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;

  // request channel, one transfer per cycle with req high
  typedef struct packed {
    logic                    req;
    logic                    we;
    logic [DATA_WIDTH/8-1:0] be;
    logic [ADDR_WIDTH-1:0]   addr;
    logic [DATA_WIDTH-1:0]   wdata;
  } obi_req_t;

  // response channel, rvalid one cycle after req
  typedef struct packed {
    logic                  rvalid;
    logic                  err;
    logic [DATA_WIDTH-1:0] rdata;
  } obi_resp_t;

endpackage

// File: hdl/mcu_map_pkg.sv
////////////////////////////////////////////////////////////////////////////
// MCU address map, always-on register offsets and bus target encoding
////////////////////////////////////////////////////////////////////////////

package mcu_map_pkg;

  localparam logic [mcu_obi_pkg::ADDR_WIDTH-1:0] RAM_START_ADDRESS       = 32'h0000_0000;
  localparam logic [mcu_obi_pkg::ADDR_WIDTH-1:0] AO_PERIPH_START_ADDRESS = 32'h2000_0000;
  localparam logic [mcu_obi_pkg::ADDR_WIDTH-1:0] AO_PERIPH_SIZE          = 32'h0000_1000;

  // decoded target of a bus request
  typedef enum logic [1:0] {
    SEL_RAM  = 2'd0,
    SEL_AO   = 2'd1,
    SEL_NONE = 2'd2
  } bus_sel_e;

  // always-on register offsets inside the 4 KiB window
  typedef enum logic [11:0] {
    EXIT_VALUE  = 12'h000,
    EXIT_VALID  = 12'h004,
    BOOT_SELECT = 12'h008,
    GPIO_OUT    = 12'h010,
    GPIO_EN     = 12'h014,
    GPIO_IN     = 12'h018
  } ao_reg_e;

endpackage

// File: hdl/ram_bank.sv
////////////////////////////////////////////////////////////////////////////
// single-port word RAM bank with byte enables and a registered read
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ram_bank #(
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mcu_obi_pkg::obi_req_t  req_i,
  output mcu_obi_pkg::obi_resp_t resp_o
);

  localparam int unsigned DW       = mcu_obi_pkg::DATA_WIDTH;
  localparam int unsigned NB       = DW / 8;
  localparam int unsigned IDX_BITS = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  logic [DW-1:0]       mem [BANK_WORDS];
  logic [IDX_BITS-1:0] idx;
  logic [DW-1:0]       rdata_q;
  logic                rvalid_q;

  // bus already stripped the address down to the word index
  assign idx = req_i.addr[IDX_BITS-1:0];

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int i = 0; i < NB; i++) begin
          if (req_i.be[i]) begin
            mem[idx][8*i +: 8] <= req_i.wdata[8*i +: 8];
          end
        end
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign resp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

endmodule

// File: hdl/ao_peripheral.sv
////////////////////////////////////////////////////////////////////////////
// always-on registers for exit status, boot select and GPIO
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module ao_peripheral #(
  parameter int unsigned GPIO_WIDTH = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mcu_obi_pkg::obi_req_t  req_i,
  output mcu_obi_pkg::obi_resp_t resp_o,
  input  logic                   boot_select_i,
  input  logic [GPIO_WIDTH-1:0]  gpio_in_i,
  output logic [GPIO_WIDTH-1:0]  gpio_out_o,
  output logic [GPIO_WIDTH-1:0]  gpio_en_o,
  output logic [31:0]            exit_value_o,
  output logic                   exit_valid_o
);

  localparam int unsigned DW = mcu_obi_pkg::DATA_WIDTH;

  mcu_map_pkg::ao_reg_e  reg_off;
  logic [DW-1:0]         rdata_d;
  logic                  known;
  logic                  writable;
  logic                  wr_en;
  logic [31:0]           exit_value_q;
  logic                  exit_valid_q;
  logic [GPIO_WIDTH-1:0] gpio_out_q;
  logic [GPIO_WIDTH-1:0] gpio_en_q;
  logic                  rvalid_q;
  logic                  err_q;
  logic [DW-1:0]         rdata_q;

  assign reg_off = mcu_map_pkg::ao_reg_e'(req_i.addr[11:0]);

  always_comb begin
    rdata_d  = '0;
    known    = 1'b1;
    writable = 1'b1;
    case (reg_off)
      mcu_map_pkg::EXIT_VALUE:  rdata_d = exit_value_q;
      mcu_map_pkg::EXIT_VALID:  rdata_d = DW'(exit_valid_q);
      mcu_map_pkg::GPIO_OUT:    rdata_d = DW'(gpio_out_q);
      mcu_map_pkg::GPIO_EN:     rdata_d = DW'(gpio_en_q);
      mcu_map_pkg::BOOT_SELECT: begin
        rdata_d  = DW'(boot_select_i);
        writable = 1'b0;
      end
      mcu_map_pkg::GPIO_IN: begin
        rdata_d  = DW'(gpio_in_i);
        writable = 1'b0;
      end
      default: begin
        known    = 1'b0;
        writable = 1'b0;
      end
    endcase
  end

  // read-only and undefined offsets are never written
  assign wr_en = req_i.req && req_i.we && writable;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_value_q <= '0;
      exit_valid_q <= 1'b0;
      gpio_out_q   <= '0;
      gpio_en_q    <= '0;
      rvalid_q     <= 1'b0;
      err_q        <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      err_q    <= req_i.req && (!known || (req_i.we && !writable));
      if (wr_en) begin
        case (reg_off)
          mcu_map_pkg::EXIT_VALUE: exit_value_q <= req_i.wdata;
          mcu_map_pkg::EXIT_VALID: exit_valid_q <= req_i.wdata[0];
          mcu_map_pkg::GPIO_OUT:   gpio_out_q   <= req_i.wdata[GPIO_WIDTH-1:0];
          mcu_map_pkg::GPIO_EN:    gpio_en_q    <= req_i.wdata[GPIO_WIDTH-1:0];
          default: ;
        endcase
      end
    end
  end

  // write responses carry no data
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : rdata_d;
    end
  end

  assign resp_o       = '{rvalid: rvalid_q, err: err_q, rdata: rdata_q};
  assign exit_value_o = exit_value_q;
  assign exit_valid_o = exit_valid_q;
  assign gpio_out_o   = gpio_out_q;
  assign gpio_en_o    = gpio_en_q;

endmodule

// File: hdl/pad_ring.sv
////////////////////////////////////////////////////////////////////////////
// pad ring: input synchronizers and enable-gated pad outputs
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module pad_ring #(
  parameter int unsigned GPIO_WIDTH = 32
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [GPIO_WIDTH-1:0] gpio_i,
  input  logic                  boot_select_i,
  input  logic [GPIO_WIDTH-1:0] gpio_out_i,
  input  logic [GPIO_WIDTH-1:0] gpio_en_i,
  output logic [GPIO_WIDTH-1:0] gpio_o,
  output logic [GPIO_WIDTH-1:0] gpio_oe_o,
  output logic [GPIO_WIDTH-1:0] gpio_in_o,
  output logic                  boot_select_o
);

  // boot select rides on top of the gpio sync chain
  logic [GPIO_WIDTH:0] sync_q1;
  logic [GPIO_WIDTH:0] sync_q2;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q1 <= '0;
      sync_q2 <= '0;
    end else begin
      sync_q1 <= {boot_select_i, gpio_i};
      sync_q2 <= sync_q1;
    end
  end

  assign gpio_in_o     = sync_q2[GPIO_WIDTH-1:0];
  assign boot_select_o = sync_q2[GPIO_WIDTH];

  // disabled pads drive zero
  assign gpio_o    = gpio_out_i & gpio_en_i;
  assign gpio_oe_o = gpio_en_i;

endmodule

// File: hdl/system_bus.sv
////////////////////////////////////////////////////////////////////////////
// system bus: decodes master requests to RAM banks, always-on registers
// or an error slave, and returns the matching response a cycle later
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module system_bus #(
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned BANK_WORDS = 256
) (
  input  logic                                    clk_i,
  input  logic                                    rst_n_i,
  input  mcu_obi_pkg::obi_req_t                   master_req_i,
  output mcu_obi_pkg::obi_resp_t                  master_resp_o,
  output mcu_obi_pkg::obi_req_t  [NUM_BANKS-1:0]  ram_req_o,
  input  mcu_obi_pkg::obi_resp_t [NUM_BANKS-1:0]  ram_resp_i,
  output mcu_obi_pkg::obi_req_t                   ao_req_o,
  input  mcu_obi_pkg::obi_resp_t                  ao_resp_i
);

  localparam int unsigned AW         = mcu_obi_pkg::ADDR_WIDTH;
  localparam int unsigned BANK_SHIFT = $clog2(NUM_BANKS);
  localparam int unsigned BANK_BITS  = (NUM_BANKS > 1) ? BANK_SHIFT : 1;
  localparam logic [AW-1:0] RAM_SIZE = NUM_BANKS * BANK_WORDS * 4;

  logic [AW-1:0]         ram_offset;
  logic [AW-1:0]         ao_offset;
  logic [AW-3:0]         word_idx;
  logic [BANK_BITS-1:0]  bank;
  logic [BANK_BITS-1:0]  bank_q;
  mcu_map_pkg::bus_sel_e sel;
  mcu_map_pkg::bus_sel_e sel_q;
  logic                  none_q;

  // offsets wrap below the base, so one compare covers each window
  assign ram_offset = master_req_i.addr - mcu_map_pkg::RAM_START_ADDRESS;
  assign ao_offset  = master_req_i.addr - mcu_map_pkg::AO_PERIPH_START_ADDRESS;
  assign word_idx   = ram_offset[AW-1:2];

  // word interleaving
  assign bank = (NUM_BANKS > 1) ? word_idx[BANK_BITS-1:0] : '0;

  always_comb begin
    if (ram_offset < RAM_SIZE) begin
      sel = mcu_map_pkg::SEL_RAM;
    end else if (ao_offset < mcu_map_pkg::AO_PERIPH_SIZE) begin
      sel = mcu_map_pkg::SEL_AO;
    end else begin
      sel = mcu_map_pkg::SEL_NONE;
    end
  end

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      ram_req_o[b]      = master_req_i;
      ram_req_o[b].req  = master_req_i.req && (sel == mcu_map_pkg::SEL_RAM) &&
                          (bank == BANK_BITS'(b));
      ram_req_o[b].addr = {2'b00, word_idx >> BANK_SHIFT};
    end
    ao_req_o      = master_req_i;
    ao_req_o.req  = master_req_i.req && (sel == mcu_map_pkg::SEL_AO);
    ao_req_o.addr = ao_offset;
  end

  // remember where the response will come from
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sel_q  <= mcu_map_pkg::SEL_NONE;
      bank_q <= '0;
      none_q <= 1'b0;
    end else begin
      none_q <= master_req_i.req && (sel == mcu_map_pkg::SEL_NONE);
      if (master_req_i.req) begin
        sel_q  <= sel;
        bank_q <= bank;
      end
    end
  end

  always_comb begin
    master_resp_o = '0;
    case (sel_q)
      mcu_map_pkg::SEL_RAM: master_resp_o = ram_resp_i[bank_q];
      mcu_map_pkg::SEL_AO:  master_resp_o = ao_resp_i;
      default: begin
        // unmapped access answers with an error
        master_resp_o.rvalid = none_q;
        master_resp_o.err    = none_q;
      end
    endcase
  end

endmodule

// File: hdl/core_v_mini_mcu.sv
////////////////////////////////////////////////////////////////////////////
// mini MCU top: system bus, RAM banks, always-on registers and pads
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_v_mini_mcu #(
  parameter int unsigned NUM_BANKS  = 2,
  parameter int unsigned BANK_WORDS = 256,
  parameter int unsigned GPIO_WIDTH = 32
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  mcu_obi_pkg::obi_req_t  master_req_i,
  output mcu_obi_pkg::obi_resp_t master_resp_o,
  input  logic                   boot_select_i,
  input  logic [GPIO_WIDTH-1:0]  gpio_i,
  output logic [GPIO_WIDTH-1:0]  gpio_o,
  output logic [GPIO_WIDTH-1:0]  gpio_oe_o,
  output logic [31:0]            exit_value_o,
  output logic                   exit_valid_o
);

  mcu_obi_pkg::obi_req_t  [NUM_BANKS-1:0] ram_req;
  mcu_obi_pkg::obi_resp_t [NUM_BANKS-1:0] ram_resp;
  mcu_obi_pkg::obi_req_t                  ao_req;
  mcu_obi_pkg::obi_resp_t                 ao_resp;

  logic [GPIO_WIDTH-1:0] gpio_in;
  logic [GPIO_WIDTH-1:0] gpio_out;
  logic [GPIO_WIDTH-1:0] gpio_en;
  logic                  boot_select;

  system_bus #(
    .NUM_BANKS (NUM_BANKS),
    .BANK_WORDS(BANK_WORDS)
  ) system_bus_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .master_req_i (master_req_i),
    .master_resp_o(master_resp_o),
    .ram_req_o    (ram_req),
    .ram_resp_i   (ram_resp),
    .ao_req_o     (ao_req),
    .ao_resp_i    (ao_resp)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : gen_bank
    ram_bank #(
      .BANK_WORDS(BANK_WORDS)
    ) ram_bank_i (
      .clk_i  (clk_i),
      .rst_n_i(rst_n_i),
      .req_i  (ram_req[b]),
      .resp_o (ram_resp[b])
    );
  end

  ao_peripheral #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) ao_peripheral_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (ao_req),
    .resp_o       (ao_resp),
    .boot_select_i(boot_select),
    .gpio_in_i    (gpio_in),
    .gpio_out_o   (gpio_out),
    .gpio_en_o    (gpio_en),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

  pad_ring #(
    .GPIO_WIDTH(GPIO_WIDTH)
  ) pad_ring_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .gpio_i       (gpio_i),
    .boot_select_i(boot_select_i),
    .gpio_out_i   (gpio_out),
    .gpio_en_i    (gpio_en),
    .gpio_o       (gpio_o),
    .gpio_oe_o    (gpio_oe_o),
    .gpio_in_o    (gpio_in),
    .boot_select_o(boot_select)
  );

endmodule

// File: testbench/core_v_mini_mcu_assert.sv
////////////////////////////////////////////////////////////////////////////
// OBI handshake and exit status assertions, bound into the bus and the
// always-on register block
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module core_v_mini_mcu_assert (
  input logic                   clk_i,
  input logic                   rst_n_i,
  input mcu_obi_pkg::obi_req_t  req_i,
  input mcu_obi_pkg::obi_resp_t resp_i,
  input logic                   exit_valid_i
);

  resp_follows_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    req_i.req |=> resp_i.rvalid)
    else $error("rvalid missing one cycle after an accepted request");

  no_stray_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_i.rvalid |-> $past(req_i.req))
    else $error("rvalid without a request in the previous cycle");

  err_needs_rvalid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    resp_i.err |-> resp_i.rvalid)
    else $error("err high without rvalid");

  // exit valid only drops on a write of zero
  exit_valid_sticky: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(exit_valid_i) |-> $past(req_i.req && req_i.we && !req_i.wdata[0] &&
                                  (req_i.addr[11:0] == mcu_map_pkg::EXIT_VALID)))
    else $error("exit_valid_o cleared without a write of zero");

endmodule

bind system_bus core_v_mini_mcu_assert bus_assert_i (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .req_i       (master_req_i),
  .resp_i      (master_resp_o),
  .exit_valid_i(1'b0)
);

bind ao_peripheral core_v_mini_mcu_assert ao_assert_i (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .req_i       (req_i),
  .resp_i      (resp_o),
  .exit_valid_i(exit_valid_o)
);

// File: testbench/tb_core_v_mini_mcu.sv
////////////////////////////////////////////////////////////////////////////
// directed bus tests of the mini MCU on RAM, always-on registers,
// GPIO pads and error responses
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_core_v_mini_mcu;

  localparam int unsigned   TIMEOUT_CYCLES = 2000;
  localparam logic [31:0]   SEED           = 32'hcbd8_7404;
  localparam logic [31:0]   AO_BASE        = mcu_map_pkg::AO_PERIPH_START_ADDRESS;
  localparam logic [31:0]   UNMAPPED_ADDR  = 32'h1000_0000;

  logic                   clk_i = 1'b0;
  logic                   rst_n_i;
  mcu_obi_pkg::obi_req_t  master_req_i;
  mcu_obi_pkg::obi_resp_t master_resp_o;
  logic                   boot_select_i;
  logic [31:0]            gpio_i;
  logic [31:0]            gpio_o;
  logic [31:0]            gpio_oe_o;
  logic [31:0]            exit_value_o;
  logic                   exit_valid_o;

  int unsigned pass_count = 0;
  int unsigned fail_count = 0;
  int unsigned cycle_count = 0;

  // values the always-on registers should hold
  logic [31:0] exp_exit_value;
  logic [31:0] exp_gpio_out;
  logic [31:0] exp_gpio_en;
  logic [31:0] exp_gpio_in;

  core_v_mini_mcu core_v_mini_mcu_i (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .master_req_i (master_req_i),
    .master_resp_o(master_resp_o),
    .boot_select_i(boot_select_i),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .gpio_oe_o    (gpio_oe_o),
    .exit_value_o (exit_value_o),
    .exit_valid_o (exit_valid_o)
  );

  always #5 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("run stopped after %0d cycles without finishing", cycle_count);
      $display("Checks failed");
      $finish;
    end
  end

  function automatic logic [31:0] ao_addr(input mcu_map_pkg::ao_reg_e r);
    return {AO_BASE[31:12], r};
  endfunction

  // byte-wise merge of a write into an old word
  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] wdata,
                                              input logic [3:0]  be);
    logic [31:0] res;
    res = old_word;
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        res[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic report_problem(input string msg);
    $display("%0t: %s", $time, msg);
    fail_count++;
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("Fail at %0t: %s got %b expected %b", $time, name, got, exp);
      fail_count++;
    end else begin
      pass_count++;
    end
  endtask

  task automatic check_resp(input string name, input mcu_obi_pkg::obi_resp_t got,
                            input mcu_obi_pkg::obi_resp_t exp);
    check_bit({name, ".err"}, got.err, exp.err);
    check_word({name, ".rdata"}, got.rdata, exp.rdata);
  endtask

  // one request with its response sampled at the falling edge a cycle later
  task automatic bus_access(input logic we, input logic [3:0] be, input logic [31:0] addr,
                            input logic [31:0] wdata, output mcu_obi_pkg::obi_resp_t resp);
    @(posedge clk_i);
    master_req_i <= '{req: 1'b1, we: we, be: be, addr: addr, wdata: wdata};
    @(negedge clk_i);
    if (master_resp_o.rvalid) begin
      report_problem($sformatf("rvalid came before the request to %h was taken", addr));
    end
    @(posedge clk_i);
    master_req_i <= '0;
    @(negedge clk_i);
    if (!master_resp_o.rvalid) begin
      report_problem($sformatf("no rvalid one cycle after the request to %h", addr));
    end
    resp = master_resp_o;
  endtask

  task automatic report_test(input string name, input int unsigned fails_before);
    $display("%s finished with %0d failures", name, fail_count - fails_before);
  endtask

  task automatic reset_defaults();
    int unsigned fails_before;
    fails_before = fail_count;
    @(negedge clk_i);
    check_bit("exit_valid_o", exit_valid_o, 1'b0);
    check_word("exit_value_o", exit_value_o, 32'h0);
    check_word("gpio_o", gpio_o, 32'h0);
    check_word("gpio_oe_o", gpio_oe_o, 32'h0);
    repeat (4) begin
      @(negedge clk_i);
      check_bit("master_resp_o.rvalid", master_resp_o.rvalid, 1'b0);
    end
    report_test("reset defaults", fails_before);
  endtask

  task automatic ram_write_read();
    int unsigned            fails_before;
    int unsigned            idx;
    logic [31:0]            addrs [20];
    logic [31:0]            data [20];
    logic [31:0]            wdata;
    mcu_obi_pkg::obi_resp_t resp;
    fails_before = fail_count;
    // distinct word indices in alternating banks
    for (int k = 0; k < 20; k++) begin
      idx      = k * 24 + $urandom_range(0, 11) * 2 + (k % 2);
      addrs[k] = idx * 4;
      data[k]  = $urandom;
      bus_access(1'b1, 4'hf, addrs[k], data[k], resp);
      check_bit("master_resp_o.err", resp.err, 1'b0);
    end
    for (int k = 0; k < 20; k++) begin
      bus_access(1'b0, 4'hf, addrs[k], 32'h0, resp);
      check_resp("ram read", resp, '{rvalid: 1'b1, err: 1'b0, rdata: data[k]});
    end
    // partial write to the lower and third byte
    wdata = $urandom;
    bus_access(1'b1, 4'b0101, addrs[3], wdata, resp);
    check_bit("master_resp_o.err", resp.err, 1'b0);
    bus_access(1'b0, 4'hf, addrs[3], 32'h0, resp);
    check_resp("ram byte write", resp,
               '{rvalid: 1'b1, err: 1'b0, rdata: merge_bytes(data[3], wdata, 4'b0101)});
    report_test("ram write read", fails_before);
  endtask

  task automatic exit_status();
    int unsigned            fails_before;
    mcu_obi_pkg::obi_resp_t resp;
    fails_before   = fail_count;
    exp_exit_value = $urandom;
    bus_access(1'b1, 4'hf, ao_addr(mcu_map_pkg::EXIT_VALUE), exp_exit_value, resp);
    check_word("exit_value_o", exit_value_o, exp_exit_value);
    bus_access(1'b1, 4'hf, ao_addr(mcu_map_pkg::EXIT_VALID), 32'h1, resp);
    check_bit("exit_valid_o", exit_valid_o, 1'b1);
    bus_access(1'b0, 4'hf, ao_addr(mcu_map_pkg::EXIT_VALUE), 32'h0, resp);
    check_resp("exit value read", resp, '{rvalid: 1'b1, err: 1'b0, rdata: exp_exit_value});
    bus_access(1'b0, 4'hf, ao_addr(mcu_map_pkg::EXIT_VALID), 32'h0, resp);
    check_resp("exit valid read", resp, '{rvalid: 1'b1, err: 1'b0, rdata: 32'h1});
    report_test("exit status", fails_before);
  endtask

  task automatic gpio_loopback();
    int unsigned            fails_before;
    mcu_obi_pkg::obi_resp_t resp;
    fails_before = fail_count;
    exp_gpio_out = $urandom;
    exp_gpio_en  = $urandom;
    bus_access(1'b1, 4'hf, ao_addr(mcu_map_pkg::GPIO_OUT), exp_gpio_out, resp);
    bus_access(1'b1, 4'hf, ao_addr(mcu_map_pkg::GPIO_EN), exp_gpio_en, resp);
    check_word("gpio_o", gpio_o, exp_gpio_out & exp_gpio_en);
    check_word("gpio_oe_o", gpio_oe_o, exp_gpio_en);
    exp_gpio_in = $urandom;
    @(posedge clk_i);
    gpio_i        <= exp_gpio_in;
    boot_select_i <= 1'b1;
    repeat (3) @(posedge clk_i);
    bus_access(1'b0, 4'hf, ao_addr(mcu_map_pkg::GPIO_IN), 32'h0, resp);
    check_resp("gpio in read", resp, '{rvalid: 1'b1, err: 1'b0, rdata: exp_gpio_in});
    bus_access(1'b0, 4'hf, ao_addr(mcu_map_pkg::BOOT_SELECT), 32'h0, resp);
    check_resp("boot select read", resp, '{rvalid: 1'b1, err: 1'b0, rdata: 32'h1});
    report_test("gpio loopback", fails_before);
  endtask

  task automatic error_responses();
    int unsigned            fails_before;
    mcu_obi_pkg::obi_resp_t resp;
    fails_before = fail_count;
    bus_access(1'b1, 4'hf, UNMAPPED_ADDR, $urandom, resp);
    check_resp("unmapped write", resp, '{rvalid: 1'b1, err: 1'b1, rdata: 32'h0});
    bus_access(1'b0, 4'hf, UNMAPPED_ADDR, 32'h0, resp);
    check_resp("unmapped read", resp, '{rvalid: 1'b1, err: 1'b1, rdata: 32'h0});
    bus_access(1'b1, 4'hf, ao_addr(mcu_map_pkg::GPIO_IN), ~exp_gpio_in, resp);
    check_bit("gpio in write err", resp.err, 1'b1);
    bus_access(1'b0, 4'hf, AO_BASE + 32'h0000_000c, 32'h0, resp);
    check_bit("undefined offset err", resp.err, 1'b1);
    // nothing above may disturb the registers
    check_word("exit_value_o", exit_value_o, exp_exit_value);
    check_bit("exit_valid_o", exit_valid_o, 1'b1);
    check_word("gpio_o", gpio_o, exp_gpio_out & exp_gpio_en);
    check_word("gpio_oe_o", gpio_oe_o, exp_gpio_en);
    bus_access(1'b0, 4'hf, ao_addr(mcu_map_pkg::GPIO_IN), 32'h0, resp);
    check_resp("gpio in after write", resp, '{rvalid: 1'b1, err: 1'b0, rdata: exp_gpio_in});
    report_test("error responses", fails_before);
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n_i       <= 1'b0;
    master_req_i  <= '0;
    boot_select_i <= 1'b0;
    gpio_i        <= '0;
    repeat (5) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);
    reset_defaults();
    ram_write_read();
    exit_status();
    gpio_loopback();
    error_responses();
    $display("checks: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: sources.f
hdl/mcu_obi_pkg.sv
hdl/mcu_map_pkg.sv
hdl/ram_bank.sv
hdl/ao_peripheral.sv
hdl/pad_ring.sv
hdl/system_bus.sv
hdl/core_v_mini_mcu.sv
testbench/core_v_mini_mcu_assert.sv
testbench/tb_core_v_mini_mcu.sv

// File: Makefile
# Verilator build and run of the mini MCU testbench

VERILATOR ?= verilator
TOP       ?= tb_core_v_mini_mcu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= All checks passed
FAIL_MSG  ?= Checks failed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

test: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failures"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
